// File: list.f
rtl/mem_map_pkg.sv
rtl/bus_pkg.sv
rtl/memory_controller.sv
rtl/instr_mem.sv
rtl/data_mem.sv
rtl/print_queue.sv
rtl/mem_subsystem.sv
verification/tb_mem_subsystem.sv

// File: rtl/bus_pkg.sv
package bus_pkg;

	// Field types come from the address map
	import mem_map_pkg::*;

	//////////////////////////////
	// CPU side
	//////////////////////////////

	// Data port request from the CPU
	// No handshake, one access per cycle
	typedef struct packed {
		addr_t addr;
		data_t wdata;
		logic  wr_en;
	} cpu_data_req_t;

	//////////////////////////////
	// Target side
	//////////////////////////////

	// Request toward main data memory
	// Address and data always forwarded, wr_en only when selected
	typedef struct packed {
		addr_t addr;
		data_t data;
		logic  wr_en;
	} mem_req_t;

	// Push request toward the print queue
	// wr_en here means push one item
	typedef struct packed {
		data_t data;
		logic  wr_en;
	} print_item_t;

endpackage

// File: rtl/data_mem.sv
module data_mem
	import mem_map_pkg::*;
	import bus_pkg::*;
(
	input  logic     clk,
	input  mem_req_t mem_req,
	output data_t    mem_rdata
);

	//////////////////////////////
	// Storage
	//////////////////////////////

	data_t     ram [DMEM_DEPTH];
	dmem_idx_t idx;

	// Word index from the low address bits
	// Upper bits alias onto the same words
	assign idx = mem_req.addr[DMEM_AW-1:0];

	// Write on the rising edge when enabled
	// New word readable from the next cycle
	always_ff @(posedge clk) begin
		if (mem_req.wr_en) begin
			ram[idx] <= mem_req.data;
		end
	end

	// Asynchronous read
	assign mem_rdata = ram[idx];

	//////////////////////////////
	// Checks
	//////////////////////////////

	// A write to an unknown address would corrupt unknown words
	a_wr_addr_known: assert property (
		@(posedge clk)
		mem_req.wr_en |-> !$isunknown(mem_req.addr)
	) else $error("data memory write with unknown address bits");

endmodule

// File: rtl/instr_mem.sv
module instr_mem
	import mem_map_pkg::*;
(
	input  addr_t  instr_addr,
	output instr_t instr_out
);

	//////////////////////////////
	// Program ROM
	//////////////////////////////

	instr_t    rom [IMEM_DEPTH];
	imem_idx_t idx;

	// Contents fixed at load time
	initial begin
		$readmemh("verification/program.hex", rom);
	end

	// High address bits ignored, so they alias
	assign idx = instr_addr[IMEM_AW-1:0];

	// Combinational fetch, same cycle as the address
	assign instr_out = rom[idx];

	//////////////////////////////
	// Checks
	//////////////////////////////

	// No clock here, checked whenever the address settles
	always_comb begin
		a_addr_known: assert final (!$isunknown(instr_addr))
			else $error("instruction address has unknown bits");
	end

endmodule

// File: rtl/mem_map_pkg.sv
package mem_map_pkg;

	//////////////////////////////
	// Bus and word widths
	//////////////////////////////

	localparam int ADDR_W  = 16;
	localparam int DATA_W  = 16;
	// Instruction words are wider than data
	localparam int INSTR_W = 18;

	//////////////////////////////
	// Memory and queue sizes
	//////////////////////////////

	localparam int DMEM_DEPTH  = 256;
	localparam int IMEM_DEPTH  = 16;
	// Power of two, pointers wrap on their own
	localparam int QUEUE_DEPTH = 4;

	// Index and pointer widths
	localparam int DMEM_AW  = $clog2(DMEM_DEPTH);
	localparam int IMEM_AW  = $clog2(IMEM_DEPTH);
	localparam int QUEUE_PW = $clog2(QUEUE_DEPTH);
	// One extra bit so a full count fits
	localparam int QUEUE_CW = $clog2(QUEUE_DEPTH + 1);

	typedef logic [ADDR_W-1:0]   addr_t;
	typedef logic [DATA_W-1:0]   data_t;
	typedef logic [INSTR_W-1:0]  instr_t;
	typedef logic [DMEM_AW-1:0]  dmem_idx_t;
	typedef logic [IMEM_AW-1:0]  imem_idx_t;
	typedef logic [QUEUE_PW-1:0] qptr_t;
	typedef logic [QUEUE_CW-1:0] qcount_t;

	//////////////////////////////
	// Memory-mapped I/O addresses
	//////////////////////////////

	// Print queue port, read gives full flag
	localparam addr_t QUEUE_ADDR = 16'h0000;
	// LCD display register, reads back zero
	localparam addr_t LCD_ADDR   = 16'h2000;

endpackage

// File: rtl/mem_subsystem.sv
module mem_subsystem
	import mem_map_pkg::*;
	import bus_pkg::*;
(
	input  logic          clk,
	input  logic          rst_n,
	input  cpu_data_req_t cpu_req,
	input  addr_t         instr_addr,
	input  logic          print_ready,
	output data_t         cpu_rdata,
	output instr_t        instr_out,
	output data_t         lcd_data,
	output data_t         print_data,
	output logic          print_valid
);

	//////////////////////////////
	// Internal nets
	//////////////////////////////

	// Controller to data memory and back
	mem_req_t    mem_req;
	data_t       mem_rdata;
	// Controller to queue, and its status back
	print_item_t print_push;
	logic        queue_full;

	//////////////////////////////
	// Data path
	//////////////////////////////

	memory_controller ctrl_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.cpu_req    (cpu_req),
		.mem_rdata  (mem_rdata),
		.queue_full (queue_full),
		.cpu_rdata  (cpu_rdata),
		.mem_req    (mem_req),
		.print_push (print_push),
		.lcd_data   (lcd_data)
	);

	data_mem dmem_i (
		.clk       (clk),
		.mem_req   (mem_req),
		.mem_rdata (mem_rdata)
	);

	print_queue queue_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.print_push  (print_push),
		.print_ready (print_ready),
		.print_data  (print_data),
		.print_valid (print_valid),
		.full        (queue_full)
	);

	// Fetch path, bypasses the controller
	instr_mem imem_i (
		.instr_addr (instr_addr),
		.instr_out  (instr_out)
	);

endmodule

// File: rtl/memory_controller.sv
module memory_controller
	import mem_map_pkg::*;
	import bus_pkg::*;
(
	input  logic          clk,
	input  logic          rst_n,
	input  cpu_data_req_t cpu_req,
	input  data_t         mem_rdata,
	input  logic          queue_full,
	output data_t         cpu_rdata,
	output mem_req_t      mem_req,
	output print_item_t   print_push,
	output data_t         lcd_data
);

	//////////////////////////////
	// Address decode
	//////////////////////////////

	logic sel_queue;
	logic sel_lcd;
	logic sel_mem;
	logic lcd_we;

	// Exact match on the full 16-bit address
	assign sel_queue = (cpu_req.addr == QUEUE_ADDR);
	assign sel_lcd   = (cpu_req.addr == LCD_ADDR);
	// Everything else falls through to main memory
	assign sel_mem   = !sel_queue && !sel_lcd;

	//////////////////////////////
	// Write steering
	//////////////////////////////

	// Same address and data to every target
	assign mem_req.addr  = cpu_req.addr;
	assign mem_req.data  = cpu_req.wdata;
	// Only the selected target sees the write
	assign mem_req.wr_en = cpu_req.wr_en && sel_mem;

	// Queue decides on its own whether to drop
	assign print_push.data  = cpu_req.wdata;
	assign print_push.wr_en = cpu_req.wr_en && sel_queue;

	// Local LCD register enable
	assign lcd_we = cpu_req.wr_en && sel_lcd;

	//////////////////////////////
	// Read data mux
	//////////////////////////////

	always_comb begin
		if (sel_queue) begin
			// Status read, full flag in bit 0
			cpu_rdata = {{(DATA_W-1){1'b0}}, queue_full};
		end else if (sel_lcd) begin
			// Write-only register
			cpu_rdata = '0;
		end else begin
			cpu_rdata = mem_rdata;
		end
	end

	//////////////////////////////
	// LCD display register
	//////////////////////////////

	// Loads on an LCD write, visible next cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			lcd_data <= '0;
		end else if (lcd_we) begin
			lcd_data <= cpu_req.wdata;
		end
	end

	//////////////////////////////
	// Checks
	//////////////////////////////

	// One write target per cycle across memory, queue and LCD
	a_one_write_target: assert property (
		@(posedge clk) disable iff (!rst_n)
		$onehot0({mem_req.wr_en, print_push.wr_en, lcd_we})
	) else $error("more than one write target enabled");

endmodule

// File: rtl/print_queue.sv
module print_queue
	import mem_map_pkg::*;
	import bus_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  print_item_t print_push,
	input  logic        print_ready,
	output data_t       print_data,
	output logic        print_valid,
	output logic        full
);

	//////////////////////////////
	// State
	//////////////////////////////

	data_t   buf_q [QUEUE_DEPTH];
	qptr_t   wr_ptr;
	qptr_t   rd_ptr;
	qcount_t count;

	logic push_ok;
	logic pop;

	//////////////////////////////
	// Flags and handshake
	//////////////////////////////

	assign full        = (count == qcount_t'(QUEUE_DEPTH));
	assign print_valid = (count != '0);

	// Push while full is silently lost
	assign push_ok = print_push.wr_en && !full;
	// Transfer on valid and ready together
	assign pop     = print_valid && print_ready;

	// Head entry, held until it is taken
	assign print_data = buf_q[rd_ptr];

	//////////////////////////////
	// Storage write
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (push_ok) begin
			buf_q[wr_ptr] <= print_push.data;
		end
	end

	//////////////////////////////
	// Pointers and count
	//////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push_ok) begin
				wr_ptr <= wr_ptr + qptr_t'(1);
			end
			if (pop) begin
				rd_ptr <= rd_ptr + qptr_t'(1);
			end
			// Push and pop together leave count as is
			case ({push_ok, pop})
				2'b10:   count <= count + qcount_t'(1);
				2'b01:   count <= count - qcount_t'(1);
				default: count <= count;
			endcase
		end
	end

	//////////////////////////////
	// Checks
	//////////////////////////////

	a_count_bound: assert property (
		@(posedge clk) disable iff (!rst_n)
		count <= qcount_t'(QUEUE_DEPTH)
	) else $error("print queue count above depth");

	// Stalled item must stay put until the consumer takes it
	a_hold_stable: assert property (
		@(posedge clk) disable iff (!rst_n)
		(print_valid && !print_ready) |=> (print_valid && $stable(print_data))
	) else $error("print data changed under back-pressure");

endmodule

// File: verification/program.hex
// One 18-bit instruction word per line, hex, ROM addresses 0 to 15 in order
1A3F5
2C04B
0F0E1
3B7D2
00C3A
25E9F
118D4
3FFFF
00001
2A5A5
15A5A
0BEEF
3C0DE
2F00D
07A31
19C6E

// File: verification/tb_mem_subsystem.sv
module tb_mem_subsystem
	import mem_map_pkg::*;
	import bus_pkg::*;
();

	//////////////////////////////
	// Run length
	//////////////////////////////

	// Rough cycle budget per test, reset first
	localparam int TEST_CYCLES     = 4 + 40 + 90 + 12 + 20 + 25;
	localparam int WATCHDOG_CYCLES = TEST_CYCLES * 2 + 100;

	logic          clk;
	logic          rst_n;
	cpu_data_req_t cpu_req;
	addr_t         instr_addr;
	logic          print_ready;
	data_t         cpu_rdata;
	instr_t        instr_out;
	data_t         lcd_data;
	data_t         print_data;
	logic          print_valid;

	// Reference model
	instr_t prog [IMEM_DEPTH];
	data_t  mem_model [DMEM_DEPTH];
	data_t  exp_print [$];
	int     exp_count;
	data_t  exp_lcd;

	// Bookkeeping
	string  cur_test;
	int     errors;
	int     errors_at_start;
	int     tests_run;
	int     tests_failed;
	integer seed;
	int     i;
	addr_t  a;
	data_t  v;
	data_t  rd;
	data_t  pushed [$];
	data_t  drained [$];

	mem_subsystem dut_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.cpu_req     (cpu_req),
		.instr_addr  (instr_addr),
		.print_ready (print_ready),
		.cpu_rdata   (cpu_rdata),
		.instr_out   (instr_out),
		.lcd_data    (lcd_data),
		.print_data  (print_data),
		.print_valid (print_valid)
	);

	always #5 clk = ~clk;

	//////////////////////////////
	// Checks against the model
	//////////////////////////////

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("MISMATCH [%s] %s: expected %0h, actual %0h", cur_test, name,
				expected, actual);
			errors++;
		end
	endtask

	// LCD register tracks the model one edge after each write
	a_lcd_model: assert property (@(posedge clk) disable iff (!rst_n) lcd_data == exp_lcd)
	else begin
		$display("MISMATCH [%s] lcd_data: expected %0h, actual %0h", cur_test,
			$sampled(exp_lcd), $sampled(lcd_data));
		errors++;
	end

	// Valid whenever the model queue holds something
	a_valid_model: assert property (
		@(posedge clk) disable iff (!rst_n) print_valid == (exp_count != 0)
	) else begin
		$display("MISMATCH [%s] print_valid: expected %0b, actual %0b", cur_test,
			$sampled(exp_count != 0), $sampled(print_valid));
		errors++;
	end

	//////////////////////////////
	// Bus tasks
	//////////////////////////////

	// All tasks start and end on a falling edge
	task automatic cpu_write(input addr_t addr, input data_t data);
		cpu_req.addr  = addr;
		cpu_req.wdata = data;
		cpu_req.wr_en = 1'b1;
		@(posedge clk);
		#1;
		// Model follows the address map
		if (addr == QUEUE_ADDR) begin
			if (exp_count < QUEUE_DEPTH) begin
				exp_print.push_back(data);
				exp_count++;
			end
		end else if (addr == LCD_ADDR) begin
			exp_lcd = data;
		end else begin
			mem_model[addr[DMEM_AW-1:0]] = data;
		end
		@(negedge clk);
		cpu_req.wr_en = 1'b0;
	endtask

	task automatic cpu_read(input addr_t addr, output data_t data);
		cpu_req.addr  = addr;
		cpu_req.wr_en = 1'b0;
		#1;
		data = cpu_rdata;
		@(negedge clk);
	endtask

	// Raise ready and take every item the model expects, head first
	task automatic drain_queue();
		print_ready = 1'b1;
		while (exp_count > 0) begin
			#1;
			check_value("drain valid", 1, print_valid);
			check_value("drain order", exp_print[0], print_data);
			// Keep what the DUT hands out on each transfer
			if (print_valid) begin
				drained.push_back(print_data);
			end
			@(posedge clk);
			#1;
			exp_print.delete(0);
			exp_count--;
			@(negedge clk);
		end
		print_ready = 1'b0;
	endtask

	task automatic start_test(input string name);
		cur_test        = name;
		errors_at_start = errors;
	endtask

	task automatic end_test();
		int n;
		n = errors - errors_at_start;
		tests_run++;
		if (n != 0) begin
			tests_failed++;
		end
		$display("test %-12s %s (%0d errors)", cur_test, (n == 0) ? "ok" : "failed", n);
	endtask

	//////////////////////////////
	// Watchdog
	//////////////////////////////

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Run timed out after %0d cycles without finishing", WATCHDOG_CYCLES);
		$display("FAIL: see errors above");
		$finish;
	end

	//////////////////////////////
	// Stimulus
	//////////////////////////////

	initial begin
		clk         = 1'b0;
		rst_n       = 1'b0;
		cpu_req     = '0;
		instr_addr  = '0;
		print_ready = 1'b0;
		exp_count   = 0;
		exp_lcd     = '0;
		errors      = 0;
		tests_run   = 0;
		tests_failed = 0;
		seed        = 51296;
		cur_test    = "reset";
		$readmemh("verification/program.hex", prog);

		repeat (4) @(negedge clk);
		rst_n = 1'b1;
		check_value("lcd after reset", 0, lcd_data);
		check_value("valid after reset", 0, print_valid);

		// Fetch, then the same words through aliased high bits
		start_test("fetch");
		for (i = 0; i < IMEM_DEPTH; i++) begin
			instr_addr = addr_t'(i);
			#1;
			check_value("fetch", prog[i], instr_out);
			@(negedge clk);
			instr_addr = {12'hB7C, 4'(i)};
			#1;
			check_value("fetch alias", prog[i], instr_out);
			@(negedge clk);
		end
		end_test();

		// Random write then readback, skipping the two device addresses
		start_test("dmem");
		for (i = 0; i < 40; i++) begin
			a = addr_t'($random(seed));
			if (a == QUEUE_ADDR || a == LCD_ADDR) begin
				a = a ^ 16'h0001;
			end
			v = data_t'($random(seed));
			cpu_write(a, v);
			cpu_read(a, rd);
			check_value("dmem readback", mem_model[a[DMEM_AW-1:0]], rd);
		end
		end_test();

		// LCD write must leave memory word 0 alone
		start_test("lcd");
		cpu_write(16'h0100, data_t'($random(seed)));
		v = data_t'($random(seed));
		cpu_write(LCD_ADDR, v);
		check_value("lcd load", exp_lcd, lcd_data);
		cpu_read(16'h0100, rd);
		check_value("dmem index 0", mem_model[0], rd);
		cpu_read(LCD_ADDR, rd);
		check_value("lcd read zero", 0, rd);
		end_test();

		// Three items under back-pressure, head held, then drained
		start_test("queue order");
		pushed.delete();
		drained.delete();
		for (i = 0; i < 3; i++) begin
			v = data_t'($random(seed));
			pushed.push_back(v);
			cpu_write(QUEUE_ADDR, v);
		end
		repeat (3) begin
			#1;
			check_value("hold valid", 1, print_valid);
			check_value("hold data", exp_print[0], print_data);
			@(negedge clk);
		end
		drain_queue();
		check_value("drain count", 3, drained.size());
		for (i = 0; i < drained.size(); i++) begin
			check_value("drain item", pushed[i], drained[i]);
		end
		end_test();

		// Six pushes into four slots, last two lost
		start_test("queue full");
		pushed.delete();
		drained.delete();
		for (i = 0; i < 6; i++) begin
			v = data_t'($random(seed));
			pushed.push_back(v);
			cpu_write(QUEUE_ADDR, v);
		end
		cpu_read(QUEUE_ADDR, rd);
		check_value("full flag set", 1, rd);
		drain_queue();
		cpu_read(QUEUE_ADDR, rd);
		check_value("full flag clear", 0, rd);
		check_value("drain count", QUEUE_DEPTH, drained.size());
		for (i = 0; i < QUEUE_DEPTH && i < drained.size(); i++) begin
			check_value("drain item", pushed[i], drained[i]);
		end
		end_test();

		$display("tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule
